/* build.f */
src/lsc_pkg.sv
src/lane_fifo.sv
src/stream_ingress.sv
src/cfg_decoder.sv
src/column_stage.sv
src/stream_egress.sv
src/lane_stream_core.sv
tb/lane_stream_core_chk.sv
tb/tb_lane_stream_core.sv

/* run.sh */
#!/bin/sh
# compile and run the lane stream core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_lane_stream_core -Mdir obj_dir -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_lane_stream_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi
exit 0

/* src/cfg_decoder.sv */
module cfg_decoder import lsc_pkg::*; #(
    parameter int NUM_COL = 3
) (
    input  logic      i_cfg_valid,
    input  cfg_word_t i_cfg,
    input  logic      i_running,
    output col_wr_t   o_wr
);

    logic accept;
    logic col_ok;

    // words while running are dropped, as are words for missing columns
    assign col_ok = (int'(i_cfg.op_w.col) < NUM_COL);
    assign accept = i_cfg_valid && !i_running && col_ok;

    always_comb begin
        o_wr = '0;
        if (i_cfg.op_w.kind == CFG_OP) begin
            o_wr.op_we = accept;
            o_wr.op    = i_cfg.op_w.op;
            o_wr.col   = i_cfg.op_w.col;
        end else begin
            // lane register load
            o_wr.reg_we = accept;
            o_wr.col    = i_cfg.load_w.col;
            o_wr.lane   = i_cfg.load_w.lane;
            o_wr.target = i_cfg.load_w.target;
            o_wr.value  = i_cfg.load_w.value;
        end
    end

endmodule

/* src/column_stage.sv */
module column_stage import lsc_pkg::*; #(
    parameter int COL_ID = 0
) (
    input  logic    clk,
    input  logic    rst,
    input  col_wr_t i_wr,
    input  beat_t   i_beat,
    input  logic    i_valid,
    input  logic    i_ready,
    output logic    o_ready,
    output beat_t   o_beat,
    output logic    o_valid
);

    col_op_e op_q;
    coef_t   coef_q [SIMD_DEGREE];
    coef_t   bias_q [SIMD_DEGREE];
    logic    hit;
    beat_t   next_beat;

    assign hit = (i_wr.col == 2'(COL_ID));

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= COL_PASS;
            for (int l = 0; l < SIMD_DEGREE; l++) begin
                coef_q[l] <= '0;
                bias_q[l] <= '0;
            end
        end else begin
            if (i_wr.op_we && hit) op_q <= i_wr.op;
            if (i_wr.reg_we && hit) begin
                if (i_wr.target) bias_q[i_wr.lane] <= i_wr.value;
                else coef_q[i_wr.lane] <= i_wr.value;
            end
        end
    end

    // per-lane function, wraps mod 2^32
    always_comb begin
        next_beat = i_beat;
        for (int l = 0; l < SIMD_DEGREE; l++) begin
            case (op_q)
                COL_MACC: next_beat.data[l] = i_beat.data[l] * LANE_W'(coef_q[l])
                                              + LANE_W'(bias_q[l]);
                COL_ADD:  next_beat.data[l] = i_beat.data[l] + LANE_W'(bias_q[l]);
                default:  next_beat.data[l] = i_beat.data[l];
            endcase
        end
    end

    assign o_ready = !o_valid || i_ready;  // empty or draining this cycle

    always_ff @(posedge clk) begin
        if (rst) o_valid <= 1'b0;
        else if (o_ready) o_valid <= i_valid;
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) o_beat <= next_beat;
    end

endmodule

/* src/lane_fifo.sv */
module lane_fifo import lsc_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  i_push,
    input  beat_t i_din,
    input  logic  i_pop,
    output beat_t o_dout,
    output logic  o_full,
    output logic  o_empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    beat_t        mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;     // one extra bit to tell full from empty
    logic          do_push;
    logic          do_pop;

    assign o_full  = (count == (AW+1)'(FIFO_DEPTH));
    assign o_empty = (count == '0);
    assign do_push = i_push && !o_full;   // push on full is dropped
    assign do_pop  = i_pop && !o_empty;

    assign o_dout = mem[rd_ptr];          // head is always visible

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2^n
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
        end
    end

endmodule

/* src/lane_stream_core.sv */
module lane_stream_core import lsc_pkg::*; #(
    parameter int NUM_COL    = 3,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    // stream in
    input  logic [SIMD_DEGREE*LANE_W-1:0] i_tdata,
    input  logic                          i_tvalid,
    output logic                          o_tready,
    input  logic                          i_tlast,
    input  logic [KEEP_W-1:0]             i_tkeep,
    // stream out
    output logic [SIMD_DEGREE*LANE_W-1:0] o_tdata,
    output logic                          o_tvalid,
    input  logic                          i_tready,
    output logic                          o_tlast,
    output logic [KEEP_W-1:0]             o_tkeep,
    // config and run control
    input  logic                          i_cfg_valid,
    input  cfg_word_t                     i_cfg,
    input  logic                          i_start,
    output logic                          o_done
);

    beat_t      chain_beat  [NUM_COL+1];  // index 0 from ingress, NUM_COL into egress
    logic [NUM_COL:0] chain_valid;
    logic [NUM_COL:0] chain_ready;
    logic       running;
    col_wr_t    wr;

    stream_ingress #(.FIFO_DEPTH(FIFO_DEPTH)) ingress (
        .clk        (clk),
        .rst        (rst),
        .i_start    (i_start),
        .i_last_out (o_done),
        .i_tdata    (i_tdata),
        .i_tvalid   (i_tvalid),
        .i_tlast    (i_tlast),
        .i_tkeep    (i_tkeep),
        .i_ready    (chain_ready[0]),
        .o_tready   (o_tready),
        .o_running  (running),
        .o_beat     (chain_beat[0]),
        .o_valid    (chain_valid[0])
    );

    cfg_decoder #(.NUM_COL(NUM_COL)) decoder (
        .i_cfg_valid (i_cfg_valid),
        .i_cfg       (i_cfg),
        .i_running   (running),
        .o_wr        (wr)
    );

    for (genvar c = 0; c < NUM_COL; c++) begin : g_col
        column_stage #(.COL_ID(c)) col (
            .clk     (clk),
            .rst     (rst),
            .i_wr    (wr),
            .i_beat  (chain_beat[c]),
            .i_valid (chain_valid[c]),
            .i_ready (chain_ready[c+1]),
            .o_ready (chain_ready[c]),
            .o_beat  (chain_beat[c+1]),
            .o_valid (chain_valid[c+1])
        );
    end

    stream_egress #(.FIFO_DEPTH(FIFO_DEPTH)) egress (
        .clk        (clk),
        .rst        (rst),
        .i_beat     (chain_beat[NUM_COL]),
        .i_valid    (chain_valid[NUM_COL]),
        .i_tready   (i_tready),
        .o_ready    (chain_ready[NUM_COL]),
        .o_tdata    (o_tdata),
        .o_tvalid   (o_tvalid),
        .o_tlast    (o_tlast),
        .o_tkeep    (o_tkeep),
        .o_last_out (o_done)
    );

endmodule

/* src/lsc_pkg.sv */
package lsc_pkg;

    localparam int SIMD_DEGREE = 4;   // lanes per beat
    localparam int LANE_W      = 32;
    localparam int KEEP_W      = 16;  // 4 bytes per lane

    typedef logic [15:0] coef_t;      // zero-extended to LANE_W when used

    typedef enum logic [1:0] {
        COL_PASS = 2'd0,
        COL_MACC = 2'd1,              // in * coef + bias
        COL_ADD  = 2'd2               // in + bias, code 3 falls back to pass
    } col_op_e;

    typedef struct packed {
        logic [SIMD_DEGREE-1:0][LANE_W-1:0] data;
        logic [SIMD_DEGREE-1:0]             lane_mask;  // lane fully kept
        logic                               last;
    } beat_t;

    typedef enum logic {
        CFG_OP   = 1'b0,
        CFG_LOAD = 1'b1
    } cfg_kind_e;

    // kind sits at bit 31 in both readings
    typedef struct packed {
        cfg_kind_e   kind;
        logic [1:0]  col;
        col_op_e     op;
        logic [26:0] pad;
    } cfg_op_t;

    typedef struct packed {
        cfg_kind_e   kind;
        logic [1:0]  col;
        logic [1:0]  lane;
        logic        target;          // 0 coef, 1 bias
        coef_t       value;
        logic [9:0]  pad;
    } cfg_load_t;

    typedef union packed {
        cfg_op_t   op_w;
        cfg_load_t load_w;
    } cfg_word_t;

    typedef struct packed {
        logic       op_we;
        col_op_e    op;
        logic       reg_we;
        logic [1:0] col;
        logic [1:0] lane;
        logic       target;
        coef_t      value;
    } col_wr_t;

endpackage

/* src/stream_egress.sv */
module stream_egress import lsc_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  beat_t                         i_beat,
    input  logic                          i_valid,
    input  logic                          i_tready,
    output logic                          o_ready,
    output logic [SIMD_DEGREE*LANE_W-1:0] o_tdata,
    output logic                          o_tvalid,
    output logic                          o_tlast,
    output logic [KEEP_W-1:0]             o_tkeep,
    output logic                          o_last_out
);

    beat_t head;
    logic  fifo_full;
    logic  fifo_empty;

    lane_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) out_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (i_valid && o_ready),
        .i_din   (i_beat),
        .i_pop   (o_tvalid && i_tready),
        .o_dout  (head),
        .o_full  (fifo_full),
        .o_empty (fifo_empty)
    );

    assign o_ready    = !fifo_full;
    assign o_tvalid   = !fifo_empty;
    assign o_tdata    = head.data;
    assign o_tlast    = head.last;
    assign o_last_out = o_tvalid && i_tready && head.last;  // ends the run

    always_comb begin
        for (int l = 0; l < SIMD_DEGREE; l++) o_tkeep[l*4 +: 4] = {4{head.lane_mask[l]}};
    end

endmodule

/* src/stream_ingress.sv */
module stream_ingress import lsc_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_start,
    input  logic                          i_last_out,
    input  logic [SIMD_DEGREE*LANE_W-1:0] i_tdata,
    input  logic                          i_tvalid,
    input  logic                          i_tlast,
    input  logic [KEEP_W-1:0]             i_tkeep,
    input  logic                          i_ready,
    output logic                          o_tready,
    output logic                          o_running,
    output beat_t                         o_beat,
    output logic                          o_valid
);

    typedef enum logic {
        S_IDLE = 1'b0,
        S_RUN  = 1'b1
    } run_state_e;

    run_state_e state;
    beat_t      in_beat;
    logic       fifo_full;
    logic       fifo_empty;

    // start opens the run, last beat out closes it
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (i_start) state <= S_RUN;
                S_RUN:   if (i_last_out) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    assign o_running = (state == S_RUN);
    assign o_tready  = o_running && !fifo_full;

    always_comb begin
        in_beat.data = i_tdata;
        in_beat.last = i_tlast;
        for (int l = 0; l < SIMD_DEGREE; l++) begin
            in_beat.lane_mask[l] = &i_tkeep[l*4 +: 4];  // partial lanes count as dropped
        end
    end

    lane_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) in_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (i_tvalid && o_tready),
        .i_din   (in_beat),
        .i_pop   (o_valid && i_ready),
        .o_dout  (o_beat),
        .o_full  (fifo_full),
        .o_empty (fifo_empty)
    );

    assign o_valid = !fifo_empty;

endmodule

/* tb/lane_stream_core_chk.sv */
module lane_stream_core_chk import lsc_pkg::*; (
    input logic                          clk,
    input logic                          rst,
    input logic [SIMD_DEGREE*LANE_W-1:0] o_tdata,
    input logic                          o_tvalid,
    input logic                          i_tready,
    input logic                          o_tlast,
    input logic [KEEP_W-1:0]             o_tkeep,
    input logic                          o_tready,
    input logic                          o_done
);

    // a stalled output beat stays put until it is taken
    a_hold: assert property (@(posedge clk) disable iff (rst)
        o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast)
                                  && $stable(o_tkeep))
        else $error("output beat changed while stalled");

    // the last beat out closes the run
    a_done: assert property (@(posedge clk) disable iff (rst)
        o_done |=> !o_tready)
        else $error("o_tready still high after o_done");

    // state is idle one edge after reset is seen
    a_rst: assert property (@(posedge clk) rst |=> !o_tready)
        else $error("o_tready high during reset");

endmodule

/* tb/tb_lane_stream_core.sv */
module tb_lane_stream_core import lsc_pkg::*; ();

    localparam int NUM_COL     = 3;
    localparam int DRV         = 10;  // drive delay after the rising edge
    localparam int TOTAL_BEATS = 20 + 40 + 24 + 60;
    localparam int MAX_CYCLES  = 20 * TOTAL_BEATS + 2000;

    logic                          clk = 1'b0;
    logic                          rst;
    logic [SIMD_DEGREE*LANE_W-1:0] i_tdata;
    logic                          i_tvalid;
    logic                          o_tready;
    logic                          i_tlast;
    logic [KEEP_W-1:0]             i_tkeep;
    logic [SIMD_DEGREE*LANE_W-1:0] o_tdata;
    logic                          o_tvalid;
    logic                          i_tready = 1'b0;
    logic                          o_tlast;
    logic [KEEP_W-1:0]             o_tkeep;
    logic                          i_cfg_valid;
    cfg_word_t                     i_cfg;
    logic                          i_start;
    logic                          o_done;

    beat_t             exp_q[$];        // expected beats in arrival order
    logic [KEEP_W-1:0] keep_q[$];       // input keep of each expected beat
    col_op_e m_op   [NUM_COL];
    coef_t   m_coef [NUM_COL][SIMD_DEGREE];
    coef_t   m_bias [NUM_COL][SIMD_DEGREE];
    integer  seed = 32'hc98c_a0c2;
    integer  sink_seed = 32'hc98c_a0c2;
    int      cycles = 0;
    int      done_count = 0;
    int      stall_count = 0;         // cycles with o_tready low mid-run under slow sink
    int      stall_until = 0;
    logic    sink_random = 1'b0;
    logic    in_run = 1'b0;

    lane_stream_core #(.NUM_COL(NUM_COL), .FIFO_DEPTH(16)) dut0 (.*);

    bind lane_stream_core lane_stream_core_chk chk0 (
        .clk      (clk),
        .rst      (rst),
        .o_tdata  (o_tdata),
        .o_tvalid (o_tvalid),
        .i_tready (i_tready),
        .o_tlast  (o_tlast),
        .o_tkeep  (o_tkeep),
        .o_tready (o_tready),
        .o_done   (o_done)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) abort_run("timeout, run did not finish within the cycle limit");
    end

    // sink, optionally stalled for a while then ready about half the time
    always @(posedge clk) begin
        #DRV;
        i_tready = !sink_random || (cycles >= stall_until && 1'($random(sink_seed)));
    end

    // one lane through every column, modulo 2^32
    function automatic logic [31:0] lane_model(input logic [31:0] x, input int l);
        logic [31:0] v;
        v = x;
        for (int c = 0; c < NUM_COL; c++) begin
            case (m_op[c])
                COL_MACC: v = v * {16'h0, m_coef[c][l]} + {16'h0, m_bias[c][l]};
                COL_ADD:  v = v + {16'h0, m_bias[c][l]};
                default:  v = v;
            endcase
        end
        return v;
    endfunction

    task automatic check_output();
        beat_t             want;
        logic [KEEP_W-1:0] want_keep;
        assert (exp_q.size() > 0) else abort_run("output beat arrived with no beat pending");
        want = exp_q.pop_front();
        want_keep = keep_q.pop_front();
        for (int l = 0; l < SIMD_DEGREE; l++) begin
            if (want.lane_mask[l]) begin
                assert (o_tdata[l*32 +: 32] == want.data[l])
                    else abort_run($sformatf("MISMATCH at %0t: o_tdata lane %0d = %h, expected %h",
                                             $time, l, o_tdata[l*32 +: 32], want.data[l]));
            end
        end
        assert (o_tkeep == want_keep)
            else abort_run($sformatf("MISMATCH at %0t: o_tkeep = %h, expected %h",
                                     $time, o_tkeep, want_keep));
        assert (o_tlast == want.last)
            else abort_run($sformatf("MISMATCH at %0t: o_tlast = %b, expected %b",
                                     $time, o_tlast, want.last));
        assert (o_done == want.last)
            else abort_run($sformatf("MISMATCH at %0t: o_done = %b, expected %b",
                                     $time, o_done, want.last));
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst && o_tvalid && i_tready) begin
            check_output();
        end else if (!rst) begin
            assert (!o_done) else abort_run("o_done pulsed without an output handshake");
        end
        if (!rst && o_done) done_count++;
        if (in_run && sink_random && !o_tready) stall_count++;
    end

    // idle only, so the model takes the word as it is driven
    task automatic write_cfg(input cfg_word_t w);
        i_cfg = w;
        i_cfg_valid = 1'b1;
        @(posedge clk);
        #DRV;
        i_cfg_valid = 1'b0;
        if (w.op_w.kind == CFG_OP) m_op[w.op_w.col] = w.op_w.op;
        else if (w.load_w.target) m_bias[w.load_w.col][w.load_w.lane] = w.load_w.value;
        else m_coef[w.load_w.col][w.load_w.lane] = w.load_w.value;
    endtask

    task automatic set_op(input int col, input col_op_e op);
        cfg_word_t w;
        w = '0;
        w.op_w.kind = CFG_OP;
        w.op_w.col = 2'(col);
        w.op_w.op = op;
        write_cfg(w);
    endtask

    task automatic load_reg(input int col, input int lane, input logic target, input coef_t val);
        cfg_word_t w;
        w = '0;
        w.load_w.kind = CFG_LOAD;
        w.load_w.col = 2'(col);
        w.load_w.lane = 2'(lane);
        w.load_w.target = target;
        w.load_w.value = val;
        write_cfg(w);
    endtask

    task automatic run_stream(input int n, input bit rand_keep, input bit cfg_mid,
                              input bit slow_sink);
        logic [3:0] m;
        beat_t      b;
        int         base;
        logic       took;
        base = done_count;
        @(negedge clk);
        assert (!o_tready) else abort_run("o_tready high before i_start");
        sink_random = slow_sink;
        stall_until = cycles + 45;  // long enough to back up every stage
        @(posedge clk);
        #DRV;
        i_start = 1'b1;
        @(posedge clk);
        #DRV;
        i_start = 1'b0;
        in_run = 1'b1;
        for (int k = 0; k < n; k++) begin
            m = rand_keep ? 4'($random(seed)) : 4'hf;
            for (int l = 0; l < SIMD_DEGREE; l++) begin
                b.data[l] = $random(seed);
                b.lane_mask[l] = m[l];
                i_tkeep[l*4 +: 4] = {4{m[l]}};
            end
            b.last = (k == n - 1);
            i_tdata = b.data;
            i_tlast = b.last;
            i_tvalid = 1'b1;
            if (cfg_mid && k == n / 2) begin
                i_cfg = '0;
                i_cfg.op_w.kind = CFG_OP;
                i_cfg.op_w.op = COL_ADD;    // would change column 0 if taken
                i_cfg_valid = 1'b1;
            end
            for (int l = 0; l < SIMD_DEGREE; l++) b.data[l] = lane_model(b.data[l], l);
            exp_q.push_back(b);
            keep_q.push_back(i_tkeep);
            do begin
                @(negedge clk);
                took = o_tready;
                @(posedge clk);
                #DRV;
            end while (!took);
            i_cfg_valid = 1'b0;
        end
        i_tvalid = 1'b0;
        while (done_count == base) @(posedge clk);
        #DRV;
        in_run = 1'b0;
        @(negedge clk);
        assert (!o_tready) else abort_run("o_tready high after o_done");
        @(posedge clk);
        #DRV;
    endtask

    initial begin
        rst = 1'b1;
        i_tdata = '0;
        i_tvalid = 1'b0;
        i_tlast = 1'b0;
        i_tkeep = '0;
        i_cfg_valid = 1'b0;
        i_cfg = '0;
        i_start = 1'b0;
        for (int c = 0; c < NUM_COL; c++) begin
            m_op[c] = COL_PASS;
            for (int l = 0; l < SIMD_DEGREE; l++) begin
                m_coef[c][l] = '0;
                m_bias[c][l] = '0;
            end
        end
        repeat (8) @(posedge clk);
        #DRV;
        rst = 1'b0;
        @(negedge clk);
        assert (!o_tvalid && !o_done) else abort_run("outputs not idle after reset");
        @(posedge clk);
        #DRV;
        run_stream(20, 1'b0, 1'b0, 1'b0);   // default pass-through
        set_op(0, COL_MACC);
        set_op(1, COL_ADD);
        set_op(2, COL_MACC);
        for (int c = 0; c < NUM_COL; c++) begin
            for (int l = 0; l < SIMD_DEGREE; l++) begin
                load_reg(c, l, 1'b0, 16'($random(seed)));
                load_reg(c, l, 1'b1, 16'($random(seed)));
            end
        end
        run_stream(40, 1'b0, 1'b0, 1'b0);
        run_stream(24, 1'b1, 1'b1, 1'b0);   // keep patterns, word while running
        run_stream(60, 1'b1, 1'b0, 1'b1);   // back-pressure
        assert (stall_count > 0) else abort_run("o_tready never dropped under back-pressure");
        $display("RESULT: PASS");
        $finish;
    end

endmodule
